// ==== compile.f ====
hdl/pt_geom_pkg.sv
hdl/pte_pkg.sv
hdl/pte_rsp_if.sv
hdl/pte_rsp_stage.sv
hdl/pt_walk_ctrl.sv
hdl/pt_walker.sv
verification/tb_pt_walker.sv

// ==== hdl/pt_geom_pkg.sv ====
// ============================================================
// Page table geometry
// Index widths, walk depth and page number types for a
// four level table of 4 KB pages with 512 entries each
// ============================================================

`default_nettype none

package pt_geom_pkg;

    // One table page holds 512 entries, so each level index is 9 bits
    localparam int PT_IDX_WIDTH = 9;
    typedef logic [PT_IDX_WIDTH-1:0] t_pt_idx;

    // Levels of indirection in a full walk
    localparam int PT_MAX_DEPTH = 4;
    typedef logic [$clog2(PT_MAX_DEPTH)-1:0] t_pt_depth;

    // All indices of one walk
    // Slot PT_MAX_DEPTH-1 holds the root level index
    typedef t_pt_idx [PT_MAX_DEPTH-1:0] t_pt_idx_vec;

    // Page numbers, 48-bit VA and 52-bit PA with 4 KB pages
    localparam int VA_PAGE_BITS = 36;
    localparam int PA_PAGE_BITS = 40;
    typedef logic [VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [PA_PAGE_BITS-1:0] t_pa_page;

    // Byte offsets within a page and within a 64-byte line
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int LINE_OFFSET_BITS = 6;

    // Memory line address
    // Physical page number on top, line index within the page below
    typedef logic [PA_PAGE_BITS+PAGE_OFFSET_BITS-LINE_OFFSET_BITS-1:0] t_line_addr;

endpackage

`default_nettype wire

// ==== hdl/pt_walk_ctrl.sv ====
// ============================================================
// Page table walk controller
// Walks the four table levels for one request at a time,
// issues line reads, decides on each decoded entry and
// registers the final response
// ============================================================

`default_nettype none

module pt_walk_ctrl #(
    parameter int LINE_WORDS = 8
) (
    input  logic                  clk,
    input  logic                  reset,

    // Table root
    input  pt_geom_pkg::t_pa_page pt_root,
    input  logic                  pt_root_valid,

    // Translation request
    input  logic                  req_en,
    input  pt_geom_pkg::t_va_page req_va,
    input  logic                  req_speculative,
    input  pte_pkg::t_req_tag     req_tag,
    output logic                  req_rdy,

    // Memory read request
    output logic                  mem_rd_en,
    output pt_geom_pkg::t_line_addr mem_rd_addr,
    input  logic                  mem_rd_rdy,

    // Decoded entries from the response stage
    pte_rsp_if.ctrl               rsp,

    // Translation response
    output logic                  rsp_en,
    output pt_geom_pkg::t_va_page rsp_va,
    output pt_geom_pkg::t_pa_page rsp_pa,
    output logic                  rsp_big_page,
    output logic                  rsp_not_present,
    output pte_pkg::t_req_tag     rsp_tag
);

    // Split of a level index into line and word within the line
    localparam int WORD_IDX_W = $clog2(LINE_WORDS);
    localparam int LINE_IDX_W = pt_geom_pkg::PT_IDX_WIDTH - WORD_IDX_W;
    localparam int TOP = pt_geom_pkg::PT_MAX_DEPTH - 1;

    // Depths of interest
    localparam pt_geom_pkg::t_pt_depth LAST_DEPTH = pt_geom_pkg::t_pt_depth'(TOP);
    localparam pt_geom_pkg::t_pt_depth BIG_DEPTH  = pt_geom_pkg::t_pt_depth'(TOP - 1);

    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        WAIT_RSP,
        DECIDE,
        DONE,
        ERROR,
        SPEC_ERROR,
        HALT
    } t_walk_state;

    t_walk_state state;

    // Root seen, registered once
    logic root_ok;

    // Request held for the whole walk
    pt_geom_pkg::t_va_page    va_q;
    logic                     spec_q;
    pte_pkg::t_req_tag        tag_q;

    // Remaining indices, current level always in the top slot
    pt_geom_pkg::t_pt_idx_vec idx_vec;
    pt_geom_pkg::t_pt_depth   depth;

    // Table page being read, translated page once done
    pt_geom_pkg::t_pa_page    cur_page;

    // Entry captured from the response stage
    pte_pkg::t_pte_status     ent_status;
    pt_geom_pkg::t_pa_page    ent_page;

    // Full line address before fitting it to the memory port
    logic [pt_geom_pkg::PA_PAGE_BITS+LINE_IDX_W-1:0] rd_line;

    // Idle and not in the registered response cycle
    assign req_rdy = root_ok && (state == IDLE) && !rsp_en;

    // ============================================================
    // Read request generation
    // ============================================================

    assign mem_rd_en    = (state == READ_REQ) && mem_rd_rdy;
    assign rd_line      = {cur_page, idx_vec[TOP][pt_geom_pkg::PT_IDX_WIDTH-1 -: LINE_IDX_W]};
    assign mem_rd_addr  = pt_geom_pkg::t_line_addr'(rd_line);
    assign rsp.word_idx = idx_vec[TOP][WORD_IDX_W-1:0];

    // ============================================================
    // Walk FSM
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= IDLE;
            root_ok <= 1'b0;
        end
        else
        begin
            root_ok <= pt_root_valid;

            case (state)
                IDLE:
                begin
                    // New walk always starts at the root
                    if (req_en && req_rdy)
                    begin
                        state    <= READ_REQ;
                        va_q     <= req_va;
                        spec_q   <= req_speculative;
                        tag_q    <= req_tag;
                        idx_vec  <= req_va;
                        depth    <= '0;
                        cur_page <= pt_root;
                    end
                end

                READ_REQ:
                begin
                    if (mem_rd_rdy)
                    begin
                        state <= WAIT_RSP;
                    end
                end

                WAIT_RSP:
                begin
                    if (rsp.valid)
                    begin
                        state      <= DECIDE;
                        ent_status <= rsp.status;
                        ent_page   <= rsp.next_page;
                    end
                end

                DECIDE:
                begin
                    cur_page <= ent_page;

                    if (ent_status.error)
                    begin
                        state <= ERROR;
                    end
                    else if (ent_status.terminal)
                    begin
                        state <= DONE;
                    end
                    else if (depth == LAST_DEPTH)
                    begin
                        // Ran out of levels without a translation
                        state <= ERROR;
                    end
                    else
                    begin
                        state <= READ_REQ;
                        depth <= depth + 1'b1;
                    end

                    // Move the next level's index into the top slot
                    for (int i = TOP; i > 0; i--)
                    begin
                        idx_vec[i] <= idx_vec[i-1];
                    end
                    idx_vec[0] <= '0;
                end

                DONE:
                begin
                    state <= IDLE;
                end

                ERROR:
                begin
                    // Speculative misses recover, others stop the walker
                    state <= spec_q ? SPEC_ERROR : HALT;
                end

                SPEC_ERROR:
                begin
                    state <= IDLE;
                end

                default:
                begin
                    // HALT holds until reset
                    state <= HALT;
                end
            endcase
        end
    end

    // ============================================================
    // Registered response
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_en <= 1'b0;
        end
        else
        begin
            rsp_en <= (state == DONE) || (state == ERROR);
        end

        rsp_va          <= va_q;
        rsp_pa          <= cur_page;
        rsp_tag         <= tag_q;
        rsp_not_present <= (state == ERROR);
        // Terminal one level above the last means a 2 MB page
        rsp_big_page    <= (state == DONE) && (depth == BIG_DEPTH);
    end

    // A decoded entry only arrives while a read is outstanding
    a_rsp_expected : assert property (@(posedge clk) disable iff (reset)
        rsp.valid |-> (state == WAIT_RSP));

    a_rsp_pulse : assert property (@(posedge clk) disable iff (reset)
        rsp_en |=> !rsp_en);

endmodule

`default_nettype wire

// ==== hdl/pt_walker.sv ====
// ============================================================
// Page table walker top level
// Joins the walk controller and the read response stage
// and exposes the request, memory and response ports
// ============================================================

`default_nettype none

module pt_walker #(
    parameter int LINE_WORDS = 8
) (
    input  logic                    clk,
    input  logic                    reset,

    // Table root
    input  pt_geom_pkg::t_pa_page   pt_root,
    input  logic                    pt_root_valid,

    // Translation request
    input  logic                    req_en,
    input  pt_geom_pkg::t_va_page   req_va,
    input  logic                    req_speculative,
    input  pte_pkg::t_req_tag       req_tag,
    output logic                    req_rdy,

    // Memory read port
    output logic                    mem_rd_en,
    output pt_geom_pkg::t_line_addr mem_rd_addr,
    input  logic                    mem_rd_rdy,
    input  logic                    mem_rd_data_en,
    input  logic [LINE_WORDS*pte_pkg::PTE_WORD_BITS-1:0] mem_rd_data,

    // Translation response
    output logic                    rsp_en,
    output pt_geom_pkg::t_va_page   rsp_va,
    output pt_geom_pkg::t_pa_page   rsp_pa,
    output logic                    rsp_big_page,
    output logic                    rsp_not_present,
    output pte_pkg::t_req_tag       rsp_tag
);

    // Decoded entries from stage to controller
    pte_rsp_if #(.LINE_WORDS(LINE_WORDS)) rsp_if ();

    pt_walk_ctrl #(
        .LINE_WORDS(LINE_WORDS)
    ) walk_ctrl (
        .clk             (clk),
        .reset           (reset),
        .pt_root         (pt_root),
        .pt_root_valid   (pt_root_valid),
        .req_en          (req_en),
        .req_va          (req_va),
        .req_speculative (req_speculative),
        .req_tag         (req_tag),
        .req_rdy         (req_rdy),
        .mem_rd_en       (mem_rd_en),
        .mem_rd_addr     (mem_rd_addr),
        .mem_rd_rdy      (mem_rd_rdy),
        .rsp             (rsp_if.ctrl),
        .rsp_en          (rsp_en),
        .rsp_va          (rsp_va),
        .rsp_pa          (rsp_pa),
        .rsp_big_page    (rsp_big_page),
        .rsp_not_present (rsp_not_present),
        .rsp_tag         (rsp_tag)
    );

    pte_rsp_stage #(
        .LINE_WORDS(LINE_WORDS)
    ) rsp_stage (
        .clk            (clk),
        .reset          (reset),
        .mem_rd_data_en (mem_rd_data_en),
        .mem_rd_data    (mem_rd_data),
        .rsp            (rsp_if.stage)
    );

endmodule

`default_nettype wire

// ==== hdl/pte_pkg.sv ====
// ============================================================
// Page table entry format
// Status bits, field positions within a 64-bit entry and
// the request tag type
// ============================================================

`default_nettype none

package pte_pkg;

    // Width of one table entry
    localparam int PTE_WORD_BITS = 64;

    // Status decoded from the low bits of an entry
    typedef struct packed
    {
        // No translation, entry is not valid
        logic error;
        // Entry holds the translated page
        logic terminal;
    } t_pte_status;

    // Bit 0 marks a translation
    localparam int PTE_TERMINAL_BIT = 0;

    // Unwritten entries are all ones, bit 3 flags them as invalid
    localparam int PTE_ERROR_BIT = 3;

    // Next table page or translated page, 40 bits from here up
    localparam int PTE_PAGE_LSB = 12;

    // Tag returned unchanged with each response
    typedef logic [7:0] t_req_tag;

endpackage

`default_nettype wire

// ==== hdl/pte_rsp_if.sv ====
// ============================================================
// Decoded entry results
// Carries one decoded entry per returned line from the
// response stage to the walk controller
// ============================================================

`default_nettype none

interface pte_rsp_if #(
    parameter int LINE_WORDS = 8
);

    // Word within the line, held by the controller until valid
    logic [$clog2(LINE_WORDS)-1:0] word_idx;

    // One cycle pulse per decoded entry
    logic                  valid;
    pte_pkg::t_pte_status  status;
    pt_geom_pkg::t_pa_page next_page;

    modport stage (input word_idx, output valid, output status, output next_page);
    modport ctrl (output word_idx, input valid, input status, input next_page);

endinterface

`default_nettype wire

// ==== hdl/pte_rsp_stage.sv ====
// ============================================================
// Page table read response stage
// Two register stages on returned lines. The second stage
// selects the addressed entry and decodes status and page
// ============================================================

`default_nettype none

module pte_rsp_stage #(
    parameter int LINE_WORDS = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,

    // Line returned from memory
    input  logic                                        mem_rd_data_en,
    input  logic [LINE_WORDS*pte_pkg::PTE_WORD_BITS-1:0] mem_rd_data,

    // Decoded entry toward the controller
    pte_rsp_if.stage                                    rsp
);

    // ============================================================
    // Stage one, capture the line
    // ============================================================

    // Line viewed as an array of entries
    logic [LINE_WORDS-1:0][pte_pkg::PTE_WORD_BITS-1:0] line_q;
    logic                                              line_en_q;

    // Entry picked from the captured line
    logic [pte_pkg::PTE_WORD_BITS-1:0]                 sel_word;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_en_q <= 1'b0;
        end
        else
        begin
            line_en_q <= mem_rd_data_en;
        end

        // Payload only moves with a returned line
        if (mem_rd_data_en)
        begin
            line_q <= mem_rd_data;
        end
    end

    // ============================================================
    // Stage two, select and decode
    // ============================================================

    // word_idx is stable from the read request until valid
    assign sel_word = line_q[rsp.word_idx];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp.valid <= 1'b0;
        end
        else
        begin
            rsp.valid <= line_en_q;
        end

        if (line_en_q)
        begin
            rsp.status.error    <= sel_word[pte_pkg::PTE_ERROR_BIT];
            rsp.status.terminal <= sel_word[pte_pkg::PTE_TERMINAL_BIT];
            rsp.next_page       <= sel_word[pte_pkg::PTE_PAGE_LSB +: pt_geom_pkg::PA_PAGE_BITS];
        end
    end

    // Only one read is outstanding, so lines never arrive back to back
    a_valid_single : assert property (@(posedge clk) disable iff (reset)
        rsp.valid |=> !rsp.valid);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_pt_walker -o tb_pt_walker
out=$(./obj_dir/tb_pt_walker)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

// ==== verification/tb_pt_walker.sv ====
// ============================================================
// Page table walker testbench
// Builds a random four level table in a memory model, runs
// 4 KB, 2 MB, unmapped and broken walks and checks every
// response and read address against a reference walk
// ============================================================

`default_nettype none

module tb_pt_walker;

    localparam int LINE_WORDS      = 8;
    localparam int WORD_BITS       = 3;
    localparam int RESET_CYCLES    = 16;
    localparam int N_4K            = 12;
    localparam int N_2M            = 6;
    localparam int N_UNMAP         = 4;
    localparam int N_BAD           = 3;
    localparam int NUM_REQ         = N_4K + N_2M + N_UNMAP + N_BAD + 1;
    localparam int WATCHDOG_CYCLES = NUM_REQ * 4 * 40 + RESET_CYCLES + 100;
    localparam logic [39:0] ROOT_PAGE = 40'h00_0000_1000;

    logic                            clk;
    logic                            reset;
    pt_geom_pkg::t_pa_page           pt_root;
    logic                            pt_root_valid;
    logic                            req_en;
    pt_geom_pkg::t_va_page           req_va;
    logic                            req_speculative;
    pte_pkg::t_req_tag               req_tag;
    logic                            req_rdy;
    logic                            mem_rd_en;
    pt_geom_pkg::t_line_addr         mem_rd_addr;
    logic                            mem_rd_rdy;
    logic                            mem_rd_data_en;
    logic [LINE_WORDS*64-1:0]        mem_rd_data;
    logic                            rsp_en;
    pt_geom_pkg::t_va_page           rsp_va;
    pt_geom_pkg::t_pa_page           rsp_pa;
    logic                            rsp_big_page;
    logic                            rsp_not_present;
    pte_pkg::t_req_tag               rsp_tag;

    // Table words keyed by {page, index}
    logic [63:0]             pt_mem [logic [48:0]];
    logic [39:0]             next_free;

    // Line addresses seen on the read port and predicted by the model
    pt_geom_pkg::t_line_addr rd_log [$];
    pt_geom_pkg::t_line_addr exp_lines [$];

    // Outstanding read in the memory model
    logic                    pend_valid;
    pt_geom_pkg::t_line_addr pend_line;
    int                      pend_cnt;

    int errors;
    int tests_ok;
    int tests_bad;

    pt_walker #(
        .LINE_WORDS(LINE_WORDS)
    ) UUT (
        .clk             (clk),
        .reset           (reset),
        .pt_root         (pt_root),
        .pt_root_valid   (pt_root_valid),
        .req_en          (req_en),
        .req_va          (req_va),
        .req_speculative (req_speculative),
        .req_tag         (req_tag),
        .req_rdy         (req_rdy),
        .mem_rd_en       (mem_rd_en),
        .mem_rd_addr     (mem_rd_addr),
        .mem_rd_rdy      (mem_rd_rdy),
        .mem_rd_data_en  (mem_rd_data_en),
        .mem_rd_data     (mem_rd_data),
        .rsp_en          (rsp_en),
        .rsp_va          (rsp_va),
        .rsp_pa          (rsp_pa),
        .rsp_big_page    (rsp_big_page),
        .rsp_not_present (rsp_not_present),
        .rsp_tag         (rsp_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // Table helpers and reference walk
    // ============================================================

    // Missing words read as all ones, error bit set
    function automatic logic [63:0] read_entry(input logic [48:0] key);
        if (pt_mem.exists(key))
        begin
            return pt_mem[key];
        end
        return '1;
    endfunction

    // Index of one level, root level at depth 0
    function automatic logic [8:0] level_index(input pt_geom_pkg::t_va_page va, input int d);
        return 9'(va >> (9 * (3 - d)));
    endfunction

    // Page in bits 51:12, terminal in bit 0, error bit 3 clear
    function automatic logic [63:0] make_entry(input logic [39:0] page, input logic term);
        return {12'h000, page, 8'h00, 3'b000, term};
    endfunction

    // Mode 0 maps a 4 KB page, 1 a 2 MB page, 2 a non-terminal leaf
    task automatic map_va(input pt_geom_pkg::t_va_page va, input int mode, input logic [39:0] pa);
        logic [39:0] page;
        logic [48:0] key;
        int          last;
        page = ROOT_PAGE;
        last = (mode == 1) ? 2 : 3;
        for (int d = 0; d < last; d++)
        begin
            key = {page, level_index(va, d)};
            // New table page where nothing usable points onward
            if (!pt_mem.exists(key) || pt_mem[key][0] || pt_mem[key][3])
            begin
                pt_mem[key] = make_entry(next_free, 1'b0);
                next_free   = next_free + 40'd1;
            end
            page = pt_mem[key][51:12];
        end
        pt_mem[{page, level_index(va, last)}] = make_entry(pa, mode != 2);
    endtask

    task automatic model_walk(input pt_geom_pkg::t_va_page va, output logic [39:0] pa,
                              output logic big, output logic np);
        logic [39:0] page;
        logic [8:0]  idx;
        logic [63:0] ent;
        page = ROOT_PAGE;
        pa   = '0;
        big  = 1'b0;
        np   = 1'b1;
        exp_lines.delete();
        for (int d = 0; d < 4; d++)
        begin
            idx = level_index(va, d);
            exp_lines.push_back({page, idx[8:WORD_BITS]});
            ent = read_entry({page, idx});
            if (ent[3])
            begin
                break;
            end
            if (ent[0])
            begin
                np  = 1'b0;
                pa  = ent[51:12];
                big = (d == 2);
                break;
            end
            // Non-terminal at depth 3 falls out of the loop as not present
            page = ent[51:12];
        end
    endtask

    // ============================================================
    // Memory model
    // ============================================================

    always
    begin
        @(negedge clk);
        mem_rd_data_en = 1'b0;
        if (pend_valid)
        begin
            if (pend_cnt == 0)
            begin
                for (int w = 0; w < LINE_WORDS; w++)
                begin
                    mem_rd_data[w*64 +: 64] = read_entry({pend_line, 3'(w)});
                end
                mem_rd_data_en = 1'b1;
                pend_valid     = 1'b0;
            end
            else
            begin
                pend_cnt--;
            end
        end
        mem_rd_rdy = ($urandom % 4) != 0;
        // Read port settles here and holds until the next rising edge
        #1;
        if (mem_rd_en)
        begin
            rd_log.push_back(mem_rd_addr);
            pend_valid = 1'b1;
            pend_line  = mem_rd_addr;
            pend_cnt   = $urandom % 6;
        end
    end

    // ============================================================
    // Test tasks
    // ============================================================

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] %s %s expected %0h actual %0h", name, what, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start)
        begin
            tests_ok++;
            $display("test %-10s ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %-10s had %0d errors", name, errors - err_start);
        end
    endtask

    // Issue one request on a falling edge and check the response
    task automatic run_walk(input string name, input pt_geom_pkg::t_va_page va, input logic spec);
        logic [39:0]       exp_pa;
        logic              exp_big;
        logic              exp_np;
        pte_pkg::t_req_tag tag;
        tag = 8'($urandom);
        model_walk(va, exp_pa, exp_big, exp_np);
        rd_log.delete();
        while (!req_rdy)
        begin
            @(negedge clk);
        end
        req_en          = 1'b1;
        req_va          = va;
        req_speculative = spec;
        req_tag         = tag;
        @(negedge clk);
        req_en = 1'b0;
        while (!rsp_en)
        begin
            @(negedge clk);
        end
        if (rsp_va !== va)
            report_mismatch(name, "rsp_va", 64'(va), 64'(rsp_va));
        if (rsp_tag !== tag)
            report_mismatch(name, "rsp_tag", 64'(tag), 64'(rsp_tag));
        if (rsp_not_present !== exp_np)
            report_mismatch(name, "rsp_not_present", 64'(exp_np), 64'(rsp_not_present));
        if (!exp_np && rsp_pa !== exp_pa)
            report_mismatch(name, "rsp_pa", 64'(exp_pa), 64'(rsp_pa));
        if (!exp_np && rsp_big_page !== exp_big)
            report_mismatch(name, "rsp_big_page", 64'(exp_big), 64'(rsp_big_page));
        if (rd_log.size() != exp_lines.size())
        begin
            $display("%s made %0d reads where %0d were due", name, rd_log.size(),
                     exp_lines.size());
            errors++;
        end
        else
        begin
            for (int i = 0; i < rd_log.size(); i++)
            begin
                if (rd_log[i] !== exp_lines[i])
                    report_mismatch(name, "mem_rd_addr", 64'(exp_lines[i]), 64'(rd_log[i]));
            end
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        int                    err_start;
        logic                  seen;
        pt_geom_pkg::t_va_page va;
        void'($urandom(32'h130a_a61c));
        errors          = 0;
        tests_ok        = 0;
        tests_bad       = 0;
        next_free       = 40'h00_0000_2000;
        pend_valid      = 1'b0;
        pend_line       = '0;
        pend_cnt        = 0;
        reset           = 1'b1;
        pt_root         = '0;
        pt_root_valid   = 1'b0;
        req_en          = 1'b0;
        req_va          = '0;
        req_speculative = 1'b0;
        req_tag         = '0;
        mem_rd_rdy      = 1'b0;
        mem_rd_data_en  = 1'b0;
        mem_rd_data     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // No readiness and no response before the root is valid
        err_start = errors;
        seen      = 1'b0;
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            if ((req_rdy !== 1'b0 || rsp_en !== 1'b0) && !seen)
            begin
                $display("req_rdy or rsp_en went high before the root was valid");
                errors++;
                seen = 1'b1;
            end
        end
        pt_root       = ROOT_PAGE;
        pt_root_valid = 1'b1;
        repeat (3) @(negedge clk);
        if (req_rdy !== 1'b1)
        begin
            $display("req_rdy did not rise after the root became valid");
            errors++;
        end
        finish_test("root_gate", err_start);

        // Mapped VAs keep the top index bit clear
        for (int i = 0; i < N_4K; i++)
        begin
            err_start = errors;
            va        = {1'b0, 35'({$urandom, $urandom})};
            map_va(va, 0, {8'($urandom), $urandom});
            run_walk($sformatf("map4k_%0d", i), va, 1'b0);
            finish_test($sformatf("map4k_%0d", i), err_start);
        end

        for (int i = 0; i < N_2M; i++)
        begin
            err_start = errors;
            va        = {1'b0, 35'({$urandom, $urandom})};
            map_va(va, 1, {31'($urandom), 9'h000});
            run_walk($sformatf("map2m_%0d", i), va, 1'b0);
            finish_test($sformatf("map2m_%0d", i), err_start);
        end

        // Unmapped VAs use root entries that are never written
        for (int i = 0; i < N_UNMAP + N_BAD; i++)
        begin
            err_start = errors;
            if (i < N_UNMAP)
            begin
                va = {1'b1, 35'({$urandom, $urandom})};
            end
            else
            begin
                va = {1'b0, 35'({$urandom, $urandom})};
                map_va(va, 2, {8'($urandom), $urandom});
            end
            run_walk($sformatf("spec_%0d", i), va, 1'b1);
            seen = 1'b0;
            for (int c = 0; c < 4 && !seen; c++)
            begin
                @(negedge clk);
                seen = req_rdy;
            end
            if (!seen)
            begin
                $display("spec_%0d req_rdy did not return after a speculative miss", i);
                errors++;
            end
            finish_test($sformatf("spec_%0d", i), err_start);
        end

        // Non-speculative miss halts the walker
        err_start = errors;
        va        = {1'b1, 35'({$urandom, $urandom})};
        run_walk("halt", va, 1'b0);
        seen = 1'b0;
        for (int c = 0; c < 50; c++)
        begin
            @(negedge clk);
            if ((req_rdy !== 1'b0 || rsp_en !== 1'b0) && !seen)
            begin
                $display("halt walker became ready or responded again after the halt");
                errors++;
                seen = 1'b1;
            end
        end
        finish_test("halt", err_start);

        $display("tests: %0d ok, %0d with errors, %0d check errors", tests_ok, tests_bad, errors);
        if (errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    // Ends a run where the walker stops responding
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, walker stopped responding", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
